//--- cache_pkg.sv
package cache_pkg;

    // Geometry
    localparam int addr_width     = 32;
    localparam int word_width     = 64;
    localparam int line_bytes     = 64;
    localparam int beats_per_line = 8;      // One AXI beat per data word
    localparam int num_sets       = 4;
    localparam int num_ways       = 2;

    // Address fields, tag | index | offset
    localparam int offset_width = 6;
    localparam int index_width  = 2;
    localparam int tag_width    = 24;

    // Core data-size codes
    localparam logic [2:0] size_byte  = 3'd1;
    localparam logic [2:0] size_half  = 3'd2;
    localparam logic [2:0] size_word  = 3'd4;
    localparam logic [2:0] size_dword = 3'd7;

    typedef logic [addr_width-1:0]       addr_t;
    typedef logic [word_width-1:0]       word_t;
    typedef logic [line_bytes*8-1:0]     line_t;
    typedef logic [tag_width-1:0]        tag_t;
    typedef logic [index_width-1:0]      index_t;
    typedef logic [$clog2(num_ways)-1:0] way_t;
    typedef logic [2:0]                  size_t;

    typedef struct packed {
        logic valid;
        logic dirty;    // Line differs from memory
        tag_t tag;
    } tag_entry_t;

endpackage

//--- axi_pkg.sv
package axi_pkg;

    // Burst shape for one cache line
    localparam logic [7:0] burst_len  = 8'd7;   // Eight beats
    localparam logic [2:0] burst_size = 3'd3;   // 8 bytes per beat

    // Burst types
    localparam logic [1:0] burst_incr = 2'd1;

    // Write and read response codes
    localparam logic [1:0] resp_okay = 2'd0;

endpackage

//--- cache_array.sv
`timescale 1ns/10ps

module cache_array #(
    parameter type entry_t = logic
) (
    input  logic              clock,
    input  logic              reset,
    input  cache_pkg::index_t rd_index,
    output entry_t            rd_entries [cache_pkg::num_ways],
    input  logic              wr_enable,
    input  cache_pkg::index_t wr_index,
    input  cache_pkg::way_t   wr_way,
    input  entry_t            wr_entry
);
    import cache_pkg::*;

    entry_t mem [num_sets][num_ways];

    // All ways of the addressed set, no read latency
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            rd_entries[w] = mem[rd_index][w];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    mem[s][w] <= '0;    // Tag instance comes up all invalid
                end
            end
        end else if (wr_enable) begin
            mem[wr_index][wr_way] <= wr_entry;
        end
    end

endmodule

//--- load_store_align.sv
`timescale 1ns/10ps

module load_store_align (
    input  cache_pkg::addr_t address,
    input  cache_pkg::size_t data_size,
    input  cache_pkg::word_t data_input,
    input  cache_pkg::line_t line_in,
    output cache_pkg::word_t load_data,
    output cache_pkg::line_t line_out
);
    import cache_pkg::*;

    logic [2:0] word_sel;
    logic [2:0] byte_sel;
    word_t      line_word;
    word_t      shifted;
    logic [7:0] byte_mask;
    word_t      bit_mask;
    word_t      store_data;

    assign word_sel = address[offset_width-1:3];
    assign byte_sel = address[2:0];

    assign line_word = line_in[word_sel * word_width +: word_width];
    assign shifted   = line_word >> {byte_sel, 3'b000};

    always_comb begin
        case (data_size)
            size_byte: begin
                load_data = {56'b0, shifted[7:0]};
                byte_mask = 8'h01;
            end
            size_half: begin
                load_data = {48'b0, shifted[15:0]};
                byte_mask = 8'h03;
            end
            size_word: begin
                load_data = {32'b0, shifted[31:0]};
                byte_mask = 8'h0f;
            end
            size_dword: begin
                load_data = shifted;
                byte_mask = 8'hff;
            end
            default: begin
                load_data = '0;     // Unknown size code
                byte_mask = 8'h00;
            end
        endcase
    end

    // Byte mask widened to bits and moved to the addressed byte lane
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            bit_mask[b*8 +: 8] = {8{byte_mask[b]}};
        end
        bit_mask = bit_mask << {byte_sel, 3'b000};
    end

    assign store_data = data_input << {byte_sel, 3'b000};

    always_comb begin
        line_out = line_in;
        line_out[word_sel * word_width +: word_width] =
            (line_word & ~bit_mask) | (store_data & bit_mask);
    end

endmodule

//--- line_fill.sv
`timescale 1ns/10ps

module line_fill (
    input  logic             clock,
    input  logic             reset,
    input  logic             fill_start,
    input  cache_pkg::addr_t fill_addr,
    output logic             fill_done,
    output cache_pkg::line_t fill_line,
    output logic             arvalid,
    input  logic             arready,
    output cache_pkg::addr_t araddr,
    output logic [7:0]       arlen,
    output logic [2:0]       arsize,
    output logic [1:0]       arburst,
    input  logic             rvalid,
    output logic             rready,
    input  cache_pkg::word_t rdata,
    input  logic             rlast
);
    import cache_pkg::*;
    import axi_pkg::*;

    logic [$clog2(beats_per_line)-1:0] beat;
    line_t                             line_buf;

    // Whole line in one INCR burst
    assign arlen   = burst_len;
    assign arsize  = burst_size;
    assign arburst = burst_incr;

    assign fill_line = line_buf;

    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            fill_done <= 1'b0;
            beat      <= '0;
        end else begin
            fill_done <= 1'b0;
            if (fill_start) begin
                arvalid <= 1'b1;
                beat    <= '0;
            end else if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;    // Accept data only once AR is taken
            end
            if (rvalid && rready) begin
                beat <= beat + 1'b1;
                if (rlast) begin
                    rready    <= 1'b0;
                    fill_done <= 1'b1;
                end
            end
        end
    end

    // Request address and beats, lowest word first
    always_ff @(posedge clock) begin
        if (fill_start) begin
            araddr <= fill_addr;
        end
        if (rvalid && rready) begin
            line_buf[beat * word_width +: word_width] <= rdata;
        end
    end

endmodule

//--- line_writeback.sv
`timescale 1ns/10ps

module line_writeback (
    input  logic             clock,
    input  logic             reset,
    input  logic             wb_start,
    input  cache_pkg::addr_t wb_addr,
    input  cache_pkg::line_t wb_line,
    output logic             wb_done,
    output logic             awvalid,
    input  logic             awready,
    output cache_pkg::addr_t awaddr,
    output logic [7:0]       awlen,
    output logic [2:0]       awsize,
    output logic [1:0]       awburst,
    output logic             wvalid,
    input  logic             wready,
    output cache_pkg::word_t wdata,
    output logic [7:0]       wstrb,
    output logic             wlast,
    input  logic             bvalid,
    output logic             bready,
    input  logic [1:0]       bresp
);
    import cache_pkg::*;
    import axi_pkg::*;

    logic [$clog2(beats_per_line)-1:0] beat;
    line_t                             line_buf;

    assign awlen   = burst_len;
    assign awsize  = burst_size;
    assign awburst = burst_incr;
    assign wstrb   = 8'hff;     // Full-line writes only

    // Beat data follows the counter, held while wready is low
    assign wdata = line_buf[beat * word_width +: word_width];
    assign wlast = wvalid && (beat == beats_per_line - 1);

    always_ff @(posedge clock) begin
        if (reset) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            wb_done <= 1'b0;
            beat    <= '0;
        end else begin
            wb_done <= 1'b0;
            if (wb_start) begin
                awvalid <= 1'b1;
                beat    <= '0;
            end else if (awvalid && awready) begin
                awvalid <= 1'b0;
                wvalid  <= 1'b1;    // Data only after the address is taken
            end
            if (wvalid && wready) begin
                beat <= beat + 1'b1;
                if (wlast) begin
                    wvalid <= 1'b0;
                    bready <= 1'b1;
                end
            end
            // Any response code ends the burst
            if (bvalid && bready) begin
                bready  <= 1'b0;
                wb_done <= 1'b1;
            end
        end
    end

    // Victim copy, the array may be refilled meanwhile
    always_ff @(posedge clock) begin
        if (wb_start) begin
            awaddr   <= wb_addr;
            line_buf <= wb_line;
        end
    end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  read_enable,
    input  logic                  write_enable,
    input  cache_pkg::addr_t      address,
    output logic                  send_enable,
    output cache_pkg::index_t     tag_rd_index,
    input  cache_pkg::tag_entry_t tag_entries [cache_pkg::num_ways],
    output logic                  tag_wr_enable,
    output cache_pkg::way_t       tag_wr_way,
    output cache_pkg::tag_entry_t tag_wr_entry,
    input  cache_pkg::line_t      data_entries [cache_pkg::num_ways],
    output logic                  data_wr_enable,
    output cache_pkg::way_t       data_wr_way,
    output cache_pkg::line_t      data_wr_line,
    output cache_pkg::line_t      sel_line,
    input  cache_pkg::line_t      merged_line,
    output logic                  fill_start,
    output cache_pkg::addr_t      fill_addr,
    input  logic                  fill_done,
    input  cache_pkg::line_t      fill_line,
    output logic                  wb_start,
    output cache_pkg::addr_t      wb_addr,
    output cache_pkg::line_t      wb_line,
    input  logic                  wb_done
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_victim,
        st_writeback,
        st_refill,
        st_install
    } state_t;

    state_t state;
    state_t next_state;
    tag_t   addr_tag;
    index_t set_index;
    logic   hit;
    way_t   hit_way;
    logic   found_free;
    way_t   victim_sel;
    way_t   victim_way;
    way_t   rr_way;
    logic   needs_wb;
    logic   store_hit;

    assign addr_tag     = address[addr_width-1 -: tag_width];
    assign set_index    = address[offset_width +: index_width];
    assign tag_rd_index = set_index;    // Victim always lives in the request's set

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (tag_entries[w].valid && tag_entries[w].tag == addr_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // First invalid way, else the round-robin pick
    always_comb begin
        found_free = 1'b0;
        victim_sel = rr_way;
        for (int w = 0; w < num_ways; w++) begin
            if (!found_free && !tag_entries[w].valid) begin
                found_free = 1'b1;
                victim_sel = way_t'(w);
            end
        end
    end

    assign needs_wb  = tag_entries[victim_sel].valid && tag_entries[victim_sel].dirty;
    assign store_hit = (state == st_lookup) && hit && write_enable;
    assign sel_line  = data_entries[hit_way];

    always_comb begin
        next_state = state;
        case (state)
            st_idle:      if ((read_enable || write_enable) && !send_enable) next_state = st_lookup;
            st_lookup:    next_state = hit ? st_respond : st_victim;
            st_respond:   next_state = st_idle;
            st_victim:    next_state = needs_wb ? st_writeback : st_refill;
            st_writeback: if (wb_done) next_state = st_refill;
            st_refill:    if (fill_done) next_state = st_install;
            st_install:   next_state = st_lookup;   // Second lookup hits
            default:      next_state = st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state       <= st_idle;
            send_enable <= 1'b0;
            rr_way      <= '0;
            victim_way  <= '0;
        end else begin
            state       <= next_state;
            send_enable <= (state == st_respond);
            if (state == st_victim) begin
                victim_way <= victim_sel;
                if (!found_free) begin
                    rr_way <= rr_way + 1'b1;    // Only when the set is full
                end
            end
        end
    end

    // Array updates: store hit merges, install writes the refilled line clean
    assign tag_wr_enable  = store_hit || (state == st_install);
    assign tag_wr_way     = (state == st_install) ? victim_way : hit_way;
    assign tag_wr_entry   = '{valid: 1'b1, dirty: store_hit, tag: addr_tag};
    assign data_wr_enable = tag_wr_enable;
    assign data_wr_way    = tag_wr_way;
    assign data_wr_line   = (state == st_install) ? fill_line : merged_line;

    // Engine requests
    assign wb_start   = (state == st_victim) && needs_wb;
    assign wb_addr    = {tag_entries[victim_sel].tag, set_index, {offset_width{1'b0}}};
    assign wb_line    = data_entries[victim_sel];
    assign fill_start = ((state == st_victim) && !needs_wb) ||
                        ((state == st_writeback) && wb_done);
    assign fill_addr  = {address[addr_width-1:offset_width], {offset_width{1'b0}}};

endmodule

//--- dcache_top.sv
`timescale 1ns/10ps

module dcache_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             read_enable,
    input  logic             write_enable,
    input  cache_pkg::addr_t address,
    input  cache_pkg::size_t data_size,
    input  cache_pkg::word_t data_input,
    output cache_pkg::word_t data_out,
    output logic             send_enable,
    output logic             arvalid,
    input  logic             arready,
    output cache_pkg::addr_t araddr,
    output logic [7:0]       arlen,
    output logic [2:0]       arsize,
    output logic [1:0]       arburst,
    input  logic             rvalid,
    output logic             rready,
    input  cache_pkg::word_t rdata,
    input  logic             rlast,
    output logic             awvalid,
    input  logic             awready,
    output cache_pkg::addr_t awaddr,
    output logic [7:0]       awlen,
    output logic [2:0]       awsize,
    output logic [1:0]       awburst,
    output logic             wvalid,
    input  logic             wready,
    output cache_pkg::word_t wdata,
    output logic [7:0]       wstrb,
    output logic             wlast,
    input  logic             bvalid,
    output logic             bready,
    input  logic [1:0]       bresp
);
    import cache_pkg::*;

    index_t     rd_index;
    tag_entry_t tag_entries [num_ways];
    logic       tag_wr_enable;
    way_t       tag_wr_way;
    tag_entry_t tag_wr_entry;
    line_t      data_entries [num_ways];
    logic       data_wr_enable;
    way_t       data_wr_way;
    line_t      data_wr_line;
    line_t      sel_line;
    line_t      merged_line;
    logic       fill_start;
    addr_t      fill_addr;
    logic       fill_done;
    line_t      fill_line;
    logic       wb_start;
    addr_t      wb_addr;
    line_t      wb_line;
    logic       wb_done;

    dcache_ctrl u_dcache_ctrl (
        .clock, .reset, .read_enable, .write_enable, .address, .send_enable,
        .tag_rd_index(rd_index), .tag_entries, .tag_wr_enable, .tag_wr_way, .tag_wr_entry,
        .data_entries, .data_wr_enable, .data_wr_way, .data_wr_line,
        .sel_line, .merged_line,
        .fill_start, .fill_addr, .fill_done, .fill_line,
        .wb_start, .wb_addr, .wb_line, .wb_done
    );

    cache_array #(.entry_t(tag_entry_t)) u_tag_array (
        .clock, .reset, .rd_index, .rd_entries(tag_entries),
        .wr_enable(tag_wr_enable), .wr_index(rd_index),
        .wr_way(tag_wr_way), .wr_entry(tag_wr_entry)
    );

    cache_array #(.entry_t(line_t)) u_data_array (
        .clock, .reset, .rd_index, .rd_entries(data_entries),
        .wr_enable(data_wr_enable), .wr_index(rd_index),
        .wr_way(data_wr_way), .wr_entry(data_wr_line)
    );

    load_store_align u_load_store_align (
        .address, .data_size, .data_input,
        .line_in(sel_line), .load_data(data_out), .line_out(merged_line)
    );

    line_fill u_line_fill (
        .clock, .reset, .fill_start, .fill_addr, .fill_done, .fill_line,
        .arvalid, .arready, .araddr, .arlen, .arsize, .arburst,
        .rvalid, .rready, .rdata, .rlast
    );

    line_writeback u_line_writeback (
        .clock, .reset, .wb_start, .wb_addr, .wb_line, .wb_done,
        .awvalid, .awready, .awaddr, .awlen, .awsize, .awburst,
        .wvalid, .wready, .wdata, .wstrb, .wlast, .bvalid, .bready, .bresp
    );

endmodule

//--- dcache_props.sv
`timescale 1ns/10ps

module dcache_props (
    input logic             clock,
    input logic             reset,
    input logic             send_enable,
    input logic             arvalid,
    input logic             arready,
    input cache_pkg::addr_t araddr,
    input logic [7:0]       arlen,
    input logic             awvalid,
    input logic             awready,
    input cache_pkg::addr_t awaddr,
    input logic [7:0]       awlen,
    input logic             wvalid,
    input logic             wready,
    input cache_pkg::word_t wdata,
    input logic             wlast
);

    send_pulse: assert property (@(posedge clock) disable iff (reset)
        send_enable |=> !send_enable)
        else $error("send_enable high for more than one cycle");

    // Payload held until the slave takes it
    ar_hold: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
        else $error("AR request changed before arready");

    aw_hold: assert property (@(posedge clock) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
        else $error("AW request changed before awready");

    w_hold: assert property (@(posedge clock) disable iff (reset)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("W beat changed before wready");

    engines_apart: assert property (@(posedge clock) disable iff (reset)
        !(arvalid && awvalid))
        else $error("arvalid and awvalid high together");

endmodule

bind dcache_top dcache_props u_dcache_props (
    .clock, .reset, .send_enable,
    .arvalid, .arready, .araddr, .arlen,
    .awvalid, .awready, .awaddr, .awlen,
    .wvalid, .wready, .wdata, .wlast
);

//--- dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb;
    import cache_pkg::*;

    localparam int    clock_period = 100;
    localparam addr_t region_base  = 32'h4000_0000;    // 2 KB region, tags collide
    localparam int    num_loads    = 40;
    localparam int    num_pairs    = 40;
    localparam int    num_repeats  = 20;
    localparam int    num_stress   = 60;
    localparam int    total_ops    = num_loads + 2 * num_pairs + 2 * num_repeats + num_stress;

    logic clock = 1'b0;
    logic reset;
    logic read_enable;
    logic write_enable;
    addr_t address;
    size_t data_size;
    word_t data_input;
    word_t data_out;
    logic send_enable;
    logic arvalid;
    logic arready;
    addr_t araddr;
    logic [7:0] arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic rvalid;
    logic rready;
    word_t rdata;
    logic rlast;
    logic awvalid;
    logic awready;
    addr_t awaddr;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic wvalid;
    logic wready;
    word_t wdata;
    logic [7:0] wstrb;
    logic wlast;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;

    logic [31:0] lfsr = 32'haeb442fc;
    logic [7:0]  golden [2048];     // Bytes as the core last wrote them
    word_t       mem [256];         // Memory behind the AXI ports
    logic        sh_valid [num_sets][num_ways];
    logic        sh_dirty [num_sets][num_ways];
    tag_t        sh_tag [num_sets][num_ways];
    way_t        sh_rr;             // One counter shared by all sets
    int          errors = 0;
    int          checks = 0;
    int          ar_count = 0;
    int          aw_count = 0;
    addr_t       last_araddr;
    addr_t       last_awaddr;
    logic        wb_pending = 1'b0;
    int          delay_bits = 1;

    dcache_top u_dcache_top (.*);

    always #(clock_period / 2) clock = ~clock;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[62:0], lfsr[0]};
        end
    endtask

    function automatic word_t fill_word(input addr_t a);
        return {a ^ 32'h9e37_79b9, ~a[15:0], a[31:16]};
    endfunction

    function automatic int size_bytes(input size_t s);
        case (s)
            3'd1:    return 1;
            3'd2:    return 2;
            3'd4:    return 4;
            default: return 8;
        endcase
    endfunction

    // Golden bytes at a, zero-extended
    function automatic word_t golden_word(input addr_t a, input int nbytes);
        word_t v;
        v = '0;
        for (int k = 0; k < nbytes; k++) begin
            v[k*8 +: 8] = golden[a[10:0] + k];
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic random_request(output size_t size, output addr_t addr);
        logic [63:0] r;
        rand_bits(2, r);
        case (r[1:0])
            2'd0:    size = 3'd1;
            2'd1:    size = 3'd2;
            2'd2:    size = 3'd4;
            default: size = 3'd7;
        endcase
        rand_bits(11, r);
        addr = region_base + (r[10:0] & ~11'(size_bytes(size) - 1));
    endtask

    // One core access, with hit, miss and write-back predicted by the shadow tags
    task automatic do_access(input logic is_store, input addr_t addr, input size_t size,
                             input word_t value);
        index_t idx;
        tag_t   tg;
        logic   hit;
        logic   free;
        way_t   way;
        logic   needs_wb;
        addr_t  wb_line_addr;
        int     ar_before;
        int     aw_before;
        int     nbytes;
        idx          = addr[offset_width +: index_width];
        tg           = addr[addr_width-1 -: tag_width];
        nbytes       = size_bytes(size);
        hit          = 1'b0;
        way          = '0;
        needs_wb     = 1'b0;
        wb_line_addr = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (sh_valid[idx][w] && sh_tag[idx][w] == tg) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            free = 1'b0;
            way  = sh_rr;
            for (int w = 0; w < num_ways; w++) begin
                if (!free && !sh_valid[idx][w]) begin
                    free = 1'b1;
                    way  = way_t'(w);
                end
            end
            if (!free) begin
                sh_rr = sh_rr + 1'b1;
            end
            needs_wb          = sh_valid[idx][way] && sh_dirty[idx][way];
            wb_line_addr      = {sh_tag[idx][way], idx, 6'b0};
            sh_valid[idx][way] = 1'b1;
            sh_dirty[idx][way] = 1'b0;
            sh_tag[idx][way]   = tg;
        end
        if (is_store) begin
            sh_dirty[idx][way] = 1'b1;
        end
        ar_before = ar_count;
        aw_before = aw_count;

        @(negedge clock);
        read_enable  = !is_store;
        write_enable = is_store;
        address      = addr;
        data_size    = size;
        data_input   = value;
        do begin
            @(negedge clock);
        end while (!send_enable);
        if (!is_store) begin
            check_value("data_out", golden_word(addr, nbytes), data_out);
        end
        read_enable  = 1'b0;
        write_enable = 1'b0;

        check_value("ar_count", !hit, ar_count - ar_before);
        check_value("aw_count", needs_wb, aw_count - aw_before);
        if (!hit) begin
            check_value("araddr", {addr[31:6], 6'b0}, last_araddr);
        end
        if (needs_wb) begin
            check_value("awaddr", wb_line_addr, last_awaddr);
        end
        if (is_store) begin
            for (int k = 0; k < nbytes; k++) begin
                golden[addr[10:0] + k] = value[k*8 +: 8];
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        $display("Test %0d %s finished with %0d errors", num, name, errors - errors_before);
    endtask

    // AXI read slave, random AR and R delays
    initial begin : read_slave
        logic [63:0] r;
        addr_t       base;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rlast   = 1'b0;
        forever begin
            @(negedge clock);
            if (arvalid) begin
                rand_bits(delay_bits, r);
                repeat (r) @(negedge clock);
                arready = 1'b1;     // Handshake at the next rising edge
                base    = araddr;
                check_value("wb_pending_at_ar", 0, wb_pending);
                check_value("araddr_offset", 0, araddr[5:0]);
                check_value("arlen", 7, arlen);
                check_value("arsize", 3, arsize);
                check_value("arburst", 1, arburst);
                ar_count++;
                last_araddr = araddr;
                @(negedge clock);
                arready = 1'b0;
                for (int b = 0; b < 8; b++) begin
                    rand_bits(delay_bits, r);
                    repeat (r) @(negedge clock);
                    rvalid = 1'b1;
                    rdata  = mem[base[10:3] + b];
                    rlast  = (b == 7);
                    while (!rready) @(negedge clock);
                    @(negedge clock);
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    // AXI write slave, checks each victim beat against the golden line
    initial begin : write_slave
        logic [63:0] r;
        addr_t       base;
        int          beat;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = 2'b00;
        forever begin
            @(negedge clock);
            if (awvalid) begin
                rand_bits(delay_bits, r);
                repeat (r) @(negedge clock);
                awready = 1'b1;
                base    = awaddr;
                check_value("awaddr_offset", 0, awaddr[5:0]);
                check_value("awlen", 7, awlen);
                check_value("awsize", 3, awsize);
                check_value("awburst", 1, awburst);
                aw_count++;
                last_awaddr = awaddr;
                wb_pending  = 1'b1;
                @(negedge clock);
                awready = 1'b0;
                beat    = 0;
                while (beat < 8) begin
                    rand_bits(1, r);
                    wready = r[0];
                    if (wvalid && wready) begin
                        check_value("wdata", golden_word(base + 8 * beat, 8), wdata);
                        check_value("wlast", beat == 7, wlast);
                        check_value("wstrb", 8'hff, wstrb);
                        mem[base[10:3] + beat] = wdata;
                        beat++;
                    end
                    @(negedge clock);
                end
                wready = 1'b0;
                rand_bits(delay_bits, r);
                repeat (r) @(negedge clock);
                bvalid = 1'b1;
                while (!bready) @(negedge clock);
                @(negedge clock);
                bvalid     = 1'b0;
                wb_pending = 1'b0;
            end
        end
    end

    initial begin : stimulus
        logic [63:0] r;
        size_t       size;
        addr_t       addr;
        addr_t       addr2;
        logic        is_store;
        int          errors_before;
        int          ar_before;
        reset        = 1'b1;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        address      = '0;
        data_size    = 3'd7;
        data_input   = '0;
        sh_rr        = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(region_base + 8 * i);
        end
        for (int j = 0; j < 2048; j++) begin
            golden[j] = mem[j / 8][(j % 8) * 8 +: 8];
        end
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = '0;
            end
        end
        repeat (16) @(negedge clock);
        reset = 1'b0;

        errors_before = errors;
        @(negedge clock);
        check_value("send_enable", 0, send_enable);
        check_value("arvalid", 0, arvalid);
        check_value("rready", 0, rready);
        check_value("awvalid", 0, awvalid);
        check_value("wvalid", 0, wvalid);
        check_value("wlast", 0, wlast);
        check_value("bready", 0, bready);
        report_test(1, "reset outputs", errors_before);

        errors_before = errors;
        for (int i = 0; i < num_loads; i++) begin
            random_request(size, addr);
            do_access(1'b0, addr, size, '0);
        end
        report_test(2, "random loads", errors_before);

        errors_before = errors;
        for (int i = 0; i < num_pairs; i++) begin
            random_request(size, addr);
            rand_bits(64, r);
            do_access(1'b1, addr, size, r);
            do_access(1'b0, addr, size, '0);    // Read back what was stored
        end
        report_test(3, "store then load", errors_before);

        errors_before = errors;
        for (int i = 0; i < num_repeats; i++) begin
            random_request(size, addr);
            rand_bits(1, r);
            is_store = r[0];
            rand_bits(64, r);
            do_access(is_store, addr, size, r);
            rand_bits(3, r);
            addr2     = {addr[31:6], r[2:0], 3'b000};
            ar_before = ar_count;
            do_access(1'b0, addr2, 3'd7, '0);
            check_value("repeat_ar_count", 0, ar_count - ar_before);
        end
        report_test(4, "repeated line access", errors_before);

        errors_before = errors;
        delay_bits    = 3;      // Up to seven idle cycles per channel
        for (int i = 0; i < num_stress; i++) begin
            random_request(size, addr);
            rand_bits(1, r);
            is_store = r[0];
            rand_bits(64, r);
            do_access(is_store, addr, size, r);
        end
        report_test(5, "back-pressure mix", errors_before);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(total_ops * 300 * clock_period);
        $display("Watchdog expired after %0d cycles, an access never completed",
                 total_ops * 300);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- dcache_top.f
cache_pkg.sv
axi_pkg.sv
cache_array.sv
load_store_align.sv
line_fill.sv
line_writeback.sv
dcache_ctrl.sv
dcache_top.sv
dcache_props.sv
dcache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module dcache_tb \
    -f dcache_top.f -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
